/* src/ddr_fb_pkg.sv */
`default_nettype none

package ddr_fb_pkg;

    typedef logic [28:0]  ddr_addr_t;   // ddr3 user address
    typedef logic [255:0] beat_t;       // one app_* data beat
    typedef logic [31:0]  word_t;       // pixel side word
    typedef logic [7:0]   burst_len_t;  // beats per burst

    // one-hot state encoding
    typedef enum logic [3:0] {
        IDLE       = 4'b0001,
        CALIB_DONE = 4'b0010,
        WRITE      = 4'b0100,
        READ       = 4'b1000
    } fb_state_t;

    localparam ddr_addr_t addr_step = 29'd8;  // 4:1 ratio, bl8

endpackage

`default_nettype wire

/* src/ddr_fb_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_fb_fsm (
    input  wire                   ui_clk,
    input  wire                   rst_n,
    input  wire                   init_calib_complete,
    input  wire                   app_rdy,
    input  wire                   app_wdf_rdy,
    input  wire                   wr_beats_ready,
    input  wire                   rd_space_ok,
    input  wire                   rd_restart,
    input  wire                   wr_burst_last,
    input  wire                   rd_burst_last,
    output logic                  app_en,
    output logic [2:0]            app_cmd,
    output logic                  app_wdf_wren,
    output logic                  app_wdf_end,
    output logic                  wr_step,
    output logic                  rd_step,
    output ddr_fb_pkg::fb_state_t state
);

    import ddr_fb_pkg::*;

    fb_state_t state_nxt;
    logic      read_armed;  // set by first rd_load edge

    assign wr_step = (state == WRITE) && app_rdy && app_wdf_rdy;
    assign rd_step = (state == READ) && app_rdy;

    assign app_en       = wr_step || rd_step;
    assign app_wdf_wren = wr_step;
    assign app_wdf_end  = wr_step;              // one data word per bl8 beat
    assign app_cmd      = (state == READ) ? 3'd1 : 3'd0;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (init_calib_complete)
                    state_nxt = CALIB_DONE;
            end
            CALIB_DONE: begin
                if (rd_restart)
                    state_nxt = CALIB_DONE;     // counter reloads this cycle
                else if (wr_beats_ready)
                    state_nxt = WRITE;          // writes win
                else if (read_armed && rd_space_ok)
                    state_nxt = READ;
            end
            WRITE: begin
                if (wr_step && wr_burst_last)
                    state_nxt = CALIB_DONE;
            end
            READ: begin
                if (rd_step && rd_burst_last)
                    state_nxt = CALIB_DONE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            read_armed <= 1'b0;
        end else if (rd_restart) begin
            read_armed <= 1'b1;                 // stays set until reset
        end
    end

endmodule

`default_nettype wire

/* src/burst_addr_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_addr_counter (
    input  wire                    ui_clk,
    input  wire                    rst_n,
    input  wire                    restart,
    input  wire                    step,
    input  wire ddr_fb_pkg::ddr_addr_t  addr_min,
    input  wire ddr_fb_pkg::ddr_addr_t  addr_max,
    input  wire ddr_fb_pkg::burst_len_t burst_len,
    output ddr_fb_pkg::ddr_addr_t  addr,
    output logic                   burst_last
);

    import ddr_fb_pkg::*;

    ddr_addr_t  min_q;
    ddr_addr_t  max_q;
    burst_len_t len_q;
    burst_len_t beat_cnt;   // beat index inside current burst

    // registered copies of the window settings
    always_ff @(posedge ui_clk) begin
        min_q <= addr_min;
        max_q <= addr_max;
        len_q <= burst_len;
    end

    assign burst_last = (beat_cnt == len_q - 8'd1);

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            addr     <= '0;
            beat_cnt <= '0;
        end else if (restart) begin
            addr     <= min_q;
            beat_cnt <= '0;
        end else if (step) begin
            if (addr >= max_q - addr_step)
                addr <= min_q;                  // wrap at end of window
            else
                addr <= addr + addr_step;
            beat_cnt <= burst_last ? '0 : beat_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* src/wr_pack_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_pack_fifo #(
    parameter int WORDS_PER_BEAT   = 8,
    parameter int FIFO_DEPTH_BEATS = 16
) (
    input  wire                         ui_clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire                         wren,
    input  wire ddr_fb_pkg::word_t      din,
    input  wire                         pop,
    input  wire ddr_fb_pkg::burst_len_t burst_len,
    output ddr_fb_pkg::beat_t           dout,
    output logic                        beats_ready
);

    import ddr_fb_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH_BEATS);
    localparam int IW = $clog2(WORDS_PER_BEAT);
    localparam int WW = $bits(word_t);

    beat_t          mem [FIFO_DEPTH_BEATS];
    beat_t          pack_q;         // partial beat being gathered
    beat_t          beat_nxt;
    logic [IW-1:0]  word_idx;
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           beat_done;
    logic           push_ok;
    logic           pop_ok;

    always_comb begin
        beat_nxt = pack_q;
        beat_nxt[word_idx * WW +: WW] = din;    // word 0 lands in low bits
    end

    assign beat_done = wren && (word_idx == IW'(WORDS_PER_BEAT - 1));
    assign push_ok   = beat_done && (int'(count) < FIFO_DEPTH_BEATS);  // full drops
    assign pop_ok    = pop && (count != '0);

    assign dout        = mem[rd_ptr];           // show-ahead
    assign beats_ready = int'(count) >= int'(burst_len);

    always_ff @(posedge ui_clk) begin
        if (wren)
            pack_q <= beat_nxt;
        if (push_ok)
            mem[wr_ptr] <= beat_nxt;
    end

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else if (flush) begin
            word_idx <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            if (wren)
                word_idx <= beat_done ? '0 : word_idx + 1'b1;
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(push_ok) - (AW+1)'(pop_ok);
        end
    end

endmodule

`default_nettype wire

/* src/rd_unpack_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_unpack_fifo #(
    parameter int WORDS_PER_BEAT   = 8,
    parameter int FIFO_DEPTH_BEATS = 16
) (
    input  wire                         ui_clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire                         push,
    input  wire ddr_fb_pkg::beat_t      din,
    input  wire                         rden,
    input  wire ddr_fb_pkg::burst_len_t burst_len,
    input  wire                         rd_issue,
    output ddr_fb_pkg::word_t           dout,
    output logic                        empty,
    output logic                        space_ok
);

    import ddr_fb_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH_BEATS);
    localparam int IW = $clog2(WORDS_PER_BEAT);
    localparam int WW = $bits(word_t);

    beat_t          mem [FIFO_DEPTH_BEATS];
    logic [IW-1:0]  word_sel;       // next word of head beat
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic [AW:0]    pending;        // read commands not yet returned
    logic           push_ok;
    logic           pop_word;
    logic           pop_beat;

    assign empty    = (count == '0);
    assign push_ok  = push && (int'(count) < FIFO_DEPTH_BEATS);
    assign pop_word = rden && !empty;
    assign pop_beat = pop_word && (word_sel == IW'(WORDS_PER_BEAT - 1));

    // a half drained head beat still counts as occupied
    assign space_ok = (FIFO_DEPTH_BEATS - int'(count)) >= (int'(burst_len) + int'(pending));

    always_ff @(posedge ui_clk) begin
        if (push_ok)
            mem[wr_ptr] <= din;
        if (pop_word)
            dout <= mem[rd_ptr][word_sel * WW +: WW];  // low word first
    end

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + (AW+1)'(rd_issue) - (AW+1)'(push);
        end
    end

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            word_sel <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else if (flush) begin
            word_sel <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            if (pop_word)
                word_sel <= pop_beat ? '0 : word_sel + 1'b1;
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_beat)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(push_ok) - (AW+1)'(pop_beat);
        end
    end

endmodule

`default_nettype wire

/* src/ddr_fb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_fb_top #(
    parameter int FIFO_DEPTH_BEATS = 16,
    parameter int WORDS_PER_BEAT   = 8
) (
    input  wire                         ui_clk,
    input  wire                         rst_n,
    input  wire                         init_calib_complete,
    input  wire                         app_rdy,
    input  wire                         app_wdf_rdy,
    input  wire                         app_rd_data_valid,
    input  wire ddr_fb_pkg::beat_t      app_rd_data,
    output ddr_fb_pkg::ddr_addr_t       app_addr,
    output logic                        app_en,
    output logic [2:0]                  app_cmd,
    output logic                        app_wdf_wren,
    output logic                        app_wdf_end,
    output ddr_fb_pkg::beat_t           app_wdf_data,
    input  wire                         wr_load,
    input  wire                         rd_load,
    input  wire ddr_fb_pkg::ddr_addr_t  app_addr_wr_min,
    input  wire ddr_fb_pkg::ddr_addr_t  app_addr_wr_max,
    input  wire ddr_fb_pkg::ddr_addr_t  app_addr_rd_min,
    input  wire ddr_fb_pkg::ddr_addr_t  app_addr_rd_max,
    input  wire ddr_fb_pkg::burst_len_t wr_bust_len,
    input  wire ddr_fb_pkg::burst_len_t rd_bust_len,
    input  wire                         wrfifo_wren,
    input  wire ddr_fb_pkg::word_t      wrfifo_din,
    input  wire                         rdfifo_rden,
    output ddr_fb_pkg::word_t           rdfifo_dout,
    output logic                        rdfifo_empty
);

    import ddr_fb_pkg::*;

    fb_state_t state;
    ddr_addr_t wr_addr;
    ddr_addr_t rd_addr;
    logic      wr_load_d0, wr_load_d1, wr_edge, wr_pend, wr_restart;
    logic      rd_load_d0, rd_load_d1, rd_edge, rd_pend, rd_restart;
    logic      in_burst;
    logic      wr_step, rd_step;
    logic      wr_burst_last, rd_burst_last;
    logic      wr_ready, rd_space_ok;

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_load_d0 <= 1'b0;
            wr_load_d1 <= 1'b0;
            rd_load_d0 <= 1'b0;
            rd_load_d1 <= 1'b0;
            wr_edge    <= 1'b0;
            rd_edge    <= 1'b0;
        end else begin
            wr_load_d0 <= wr_load;
            wr_load_d1 <= wr_load_d0;
            rd_load_d0 <= rd_load;
            rd_load_d1 <= rd_load_d0;
            wr_edge    <= wr_load_d0 && !wr_load_d1;    // rising edges
            rd_edge    <= rd_load_d0 && !rd_load_d1;
        end
    end

    // an edge that arrives mid burst waits for CALIB_DONE
    assign in_burst   = (state == WRITE) || (state == READ);
    assign wr_restart = (wr_edge || wr_pend) && !in_burst;
    assign rd_restart = (rd_edge || rd_pend) && !in_burst;

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            wr_pend <= (wr_edge || wr_pend) && !wr_restart;
            rd_pend <= (rd_edge || rd_pend) && !rd_restart;
        end
    end

    assign app_addr = (state == READ) ? rd_addr : wr_addr;

    ddr_fb_fsm i_fsm (
        .ui_clk              (ui_clk),
        .rst_n               (rst_n),
        .init_calib_complete (init_calib_complete),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .wr_beats_ready      (wr_ready && !wr_restart),  // no burst on restart
        .rd_space_ok         (rd_space_ok),
        .rd_restart          (rd_restart),
        .wr_burst_last       (wr_burst_last),
        .rd_burst_last       (rd_burst_last),
        .app_en              (app_en),
        .app_cmd             (app_cmd),
        .app_wdf_wren        (app_wdf_wren),
        .app_wdf_end         (app_wdf_end),
        .wr_step             (wr_step),
        .rd_step             (rd_step),
        .state               (state)
    );

    burst_addr_counter i_wr_addr (
        .ui_clk     (ui_clk),
        .rst_n      (rst_n),
        .restart    (wr_restart),
        .step       (wr_step),
        .addr_min   (app_addr_wr_min),
        .addr_max   (app_addr_wr_max),
        .burst_len  (wr_bust_len),
        .addr       (wr_addr),
        .burst_last (wr_burst_last)
    );

    burst_addr_counter i_rd_addr (
        .ui_clk     (ui_clk),
        .rst_n      (rst_n),
        .restart    (rd_restart),
        .step       (rd_step),
        .addr_min   (app_addr_rd_min),
        .addr_max   (app_addr_rd_max),
        .burst_len  (rd_bust_len),
        .addr       (rd_addr),
        .burst_last (rd_burst_last)
    );

    wr_pack_fifo #(
        .WORDS_PER_BEAT   (WORDS_PER_BEAT),
        .FIFO_DEPTH_BEATS (FIFO_DEPTH_BEATS)
    ) i_wr_fifo (
        .ui_clk      (ui_clk),
        .rst_n       (rst_n),
        .flush       (wr_restart),
        .wren        (wrfifo_wren),
        .din         (wrfifo_din),
        .pop         (wr_step),
        .burst_len   (wr_bust_len),
        .dout        (app_wdf_data),
        .beats_ready (wr_ready)
    );

    rd_unpack_fifo #(
        .WORDS_PER_BEAT   (WORDS_PER_BEAT),
        .FIFO_DEPTH_BEATS (FIFO_DEPTH_BEATS)
    ) i_rd_fifo (
        .ui_clk    (ui_clk),
        .rst_n     (rst_n),
        .flush     (rd_restart),
        .push      (app_rd_data_valid),
        .din       (app_rd_data),
        .rden      (rdfifo_rden),
        .burst_len (rd_bust_len),
        .rd_issue  (rd_step),
        .dout      (rdfifo_dout),
        .empty     (rdfifo_empty),
        .space_ok  (rd_space_ok)
    );

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic ui_clk,
    output logic rst_n
);

    initial begin
        ui_clk = 1'b0;
        forever #50 ui_clk = ~ui_clk;      // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge ui_clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/ddr_fb_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_fb_sva (
    input wire                   ui_clk,
    input wire                   rst_n,
    input wire                   app_en,
    input wire [2:0]             app_cmd,
    input wire                   app_wdf_wren,
    input wire                   app_wdf_end,
    input wire                   app_rdy,
    input ddr_fb_pkg::fb_state_t state
);

    import ddr_fb_pkg::*;

    a_wren_has_en: assert property (@(posedge ui_clk) disable iff (!rst_n)
        app_wdf_wren |-> (app_en && app_wdf_end))
        else $error("app_wdf_wren without app_en and app_wdf_end");

    a_rd_cmd_in_read: assert property (@(posedge ui_clk) disable iff (!rst_n)
        (app_cmd == 3'd1) |-> (state == READ))
        else $error("read command outside READ");

    a_en_needs_rdy: assert property (@(posedge ui_clk) disable iff (!rst_n)
        app_en |-> app_rdy)
        else $error("app_en while app_rdy low");

endmodule

bind ddr_fb_fsm ddr_fb_sva i_sva (.*);

`default_nettype wire

/* bench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire                        ui_clk,
    input  wire                        rst_n,
    input  wire                        wr_load,
    input  wire                        rd_load,
    input  wire ddr_fb_pkg::ddr_addr_t wr_min,
    input  wire ddr_fb_pkg::ddr_addr_t wr_max,
    input  wire ddr_fb_pkg::ddr_addr_t rd_min,
    input  wire ddr_fb_pkg::ddr_addr_t rd_max,
    input  ddr_fb_pkg::word_t          frame [64],
    input  wire ddr_fb_pkg::ddr_addr_t app_addr,
    input  wire                        app_en,
    input  wire [2:0]                  app_cmd,
    input  wire                        app_wdf_wren,
    input  wire                        app_wdf_end,
    input  wire ddr_fb_pkg::beat_t     app_wdf_data,
    input  wire                        app_rd_data_valid,
    input  wire                        rdfifo_rden,
    input  wire                        rdfifo_empty,
    input  wire ddr_fb_pkg::word_t     rdfifo_dout,
    input  wire                        report,
    input  wire [31:0]                 exp_wr_beats,
    input  wire [31:0]                 exp_rd_words,
    output integer                     errors,
    output integer                     wr_beats,
    output integer                     rd_words,
    output logic                       done
);

    import ddr_fb_pkg::*;

    ddr_addr_t exp_wr_addr;
    ddr_addr_t exp_rd_addr;
    beat_t     exp_beat;
    logic      wr_load_q, rd_load_q;
    logic      wr_seen, rd_data_seen;
    logic      pop_q;
    integer    k;
    integer    w;

    initial begin
        errors       = 0;
        wr_beats     = 0;
        rd_words     = 0;
        done         = 1'b0;
        wr_load_q    = 1'b0;
        rd_load_q    = 1'b0;
        wr_seen      = 1'b0;
        rd_data_seen = 1'b0;
        pop_q        = 1'b0;
    end

    always @(posedge ui_clk) begin
        if (rst_n) begin
            if (wr_load && !wr_load_q) begin
                exp_wr_addr = wr_min;           // restart expected at window start
                wr_seen     = 1'b1;
            end
            if (rd_load && !rd_load_q)
                exp_rd_addr = rd_min;
            wr_load_q = wr_load;
            rd_load_q = rd_load;

            if (!wr_seen && (app_en || app_wdf_wren)) begin
                $display("error at %0t: app_en or app_wdf_wren active before any load", $time);
                errors = errors + 1;
            end
            if (!rd_data_seen && !rdfifo_empty) begin
                $display("error at %0t: rdfifo_empty low before read data", $time);
                errors = errors + 1;
            end
            if (app_rd_data_valid)
                rd_data_seen = 1'b1;

            // last data word flag only on a write beat
            if (app_wdf_end !== (app_en && app_wdf_wren)) begin
                $display("error at %0t: app_wdf_end is %b, expected %b",
                         $time, app_wdf_end, app_en && app_wdf_wren);
                errors = errors + 1;
            end

            if (app_en && app_wdf_wren) begin
                if (app_addr !== exp_wr_addr) begin
                    $display("error at %0t: write addr %h, expected %h",
                             $time, app_addr, exp_wr_addr);
                    errors = errors + 1;
                end
                if (app_cmd !== 3'd0) begin
                    $display("error at %0t: write beat with app_cmd %0d", $time, app_cmd);
                    errors = errors + 1;
                end
                k = int'((exp_wr_addr - wr_min) >> 3) % 8;   // beat slot in frame
                for (w = 0; w < 8; w = w + 1)
                    exp_beat[w*32 +: 32] = frame[k*8 + w];
                if (app_wdf_data !== exp_beat) begin
                    $display("error at %0t: write beat %0d data mismatch", $time, k);
                    errors = errors + 1;
                end
                if (exp_wr_addr >= wr_max - 29'd8)
                    exp_wr_addr = wr_min;
                else
                    exp_wr_addr = exp_wr_addr + 29'd8;
                wr_beats = wr_beats + 1;
            end

            if (app_en && (app_cmd == 3'd1)) begin
                if (app_addr !== exp_rd_addr) begin
                    $display("error at %0t: read addr %h, expected %h",
                             $time, app_addr, exp_rd_addr);
                    errors = errors + 1;
                end
                if (exp_rd_addr >= rd_max - 29'd8)
                    exp_rd_addr = rd_min;
                else
                    exp_rd_addr = exp_rd_addr + 29'd8;
            end

            // dout is valid one cycle after the pop
            if (pop_q) begin
                if (rdfifo_dout !== frame[rd_words % 64]) begin
                    $display("error at %0t: read word %0d is %h, expected %h",
                             $time, rd_words, rdfifo_dout, frame[rd_words % 64]);
                    errors = errors + 1;
                end
                rd_words <= rd_words + 1;
            end
            pop_q = rdfifo_rden && !rdfifo_empty;

            if (report && !done) begin
                if (wr_beats != int'(exp_wr_beats)) begin
                    $display("write beat count is %0d, expected %0d", wr_beats, exp_wr_beats);
                    errors = errors + 1;
                end
                if (rd_words < int'(exp_rd_words)) begin
                    $display("only %0d read words arrived, expected %0d",
                             rd_words, exp_rd_words);
                    errors = errors + 1;
                end
                $display("checks done: %0d errors, %0d write beats, %0d read words",
                         errors, wr_beats, rd_words);
                done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_ddr_fb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_fb;

    import ddr_fb_pkg::*;

    localparam int TIMEOUT_CYCLES = 64 * 40;

    logic ui_clk, rst_n;
    logic init_calib_complete, app_rdy, app_wdf_rdy, app_rd_data_valid;
    beat_t app_rd_data, app_wdf_data;
    ddr_addr_t app_addr, wr_min, wr_max, rd_min, rd_max;
    logic app_en, app_wdf_wren, app_wdf_end;
    logic [2:0] app_cmd;
    logic wr_load, rd_load, wrfifo_wren, rdfifo_rden, rdfifo_empty;
    burst_len_t wr_len, rd_len;
    word_t wrfifo_din, rdfifo_dout;

    logic [31:0] tdata [0:69];     // bounds, lengths, then the frame
    word_t       frame [64];
    beat_t       mem [ddr_addr_t];  // sparse DDR3 model
    ddr_addr_t   rd_addr_q [$];
    integer      rd_due_q [$];
    integer      seed;
    integer      cycles;
    integer      mem_beats;
    integer      errors, wr_beats, rd_words;
    logic        report, chk_done;
    integer      i;

    tb_clk_gen i_clk_gen (.ui_clk(ui_clk), .rst_n(rst_n));

    ddr_fb_top i_dut (
        .ui_clk(ui_clk), .rst_n(rst_n),
        .init_calib_complete(init_calib_complete),
        .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
        .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
        .app_addr(app_addr), .app_en(app_en), .app_cmd(app_cmd),
        .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
        .app_wdf_data(app_wdf_data),
        .wr_load(wr_load), .rd_load(rd_load),
        .app_addr_wr_min(wr_min), .app_addr_wr_max(wr_max),
        .app_addr_rd_min(rd_min), .app_addr_rd_max(rd_max),
        .wr_bust_len(wr_len), .rd_bust_len(rd_len),
        .wrfifo_wren(wrfifo_wren), .wrfifo_din(wrfifo_din),
        .rdfifo_rden(rdfifo_rden), .rdfifo_dout(rdfifo_dout),
        .rdfifo_empty(rdfifo_empty)
    );

    tb_checker i_checker (
        .ui_clk(ui_clk), .rst_n(rst_n), .wr_load(wr_load), .rd_load(rd_load),
        .wr_min(wr_min), .wr_max(wr_max), .rd_min(rd_min), .rd_max(rd_max),
        .frame(frame), .app_addr(app_addr), .app_en(app_en), .app_cmd(app_cmd),
        .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
        .app_wdf_data(app_wdf_data),
        .app_rd_data_valid(app_rd_data_valid), .rdfifo_rden(rdfifo_rden),
        .rdfifo_empty(rdfifo_empty), .rdfifo_dout(rdfifo_dout),
        .report(report), .exp_wr_beats(32'd12), .exp_rd_words(32'd128),
        .errors(errors), .wr_beats(wr_beats), .rd_words(rd_words), .done(chk_done)
    );

    // memory model with random back-pressure and 4-cycle read latency
    always @(posedge ui_clk) begin
        cycles <= cycles + 1;
        app_rdy     <= ($random(seed) & 3) != 0;
        app_wdf_rdy <= ($random(seed) & 3) != 0;
        if (app_en && app_wdf_wren) begin
            mem[app_addr] = app_wdf_data;
            mem_beats <= mem_beats + 1;
        end
        if (app_en && (app_cmd == 3'd1)) begin
            rd_addr_q.push_back(app_addr);
            rd_due_q.push_back(cycles + 4);
        end
        app_rd_data_valid <= 1'b0;
        if (rd_due_q.size() > 0 && rd_due_q[0] == cycles) begin
            app_rd_data_valid <= 1'b1;
            app_rd_data <= mem.exists(rd_addr_q[0]) ? mem[rd_addr_q[0]] : '0;
            void'(rd_addr_q.pop_front());
            void'(rd_due_q.pop_front());
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic pulse_load(input logic is_wr);
        @(posedge ui_clk);
        if (is_wr) wr_load <= 1'b1;
        else       rd_load <= 1'b1;
        @(posedge ui_clk);
        wr_load <= 1'b0;
        rd_load <= 1'b0;
        repeat (5) @(posedge ui_clk);          // restart lands 3 cycles later
    endtask

    task automatic push_words(input integer count);
        integer n;
        for (n = 0; n < count; n = n + 1) begin
            @(posedge ui_clk);
            wrfifo_wren <= 1'b1;
            wrfifo_din  <= frame[n];
        end
        @(posedge ui_clk);
        wrfifo_wren <= 1'b0;
    endtask

    initial begin
        $readmemh("bench/ddr_fb_testdata.hex", tdata);
        wr_min = tdata[0][28:0];
        wr_max = tdata[1][28:0];
        rd_min = tdata[2][28:0];
        rd_max = tdata[3][28:0];
        wr_len = tdata[4][7:0];
        rd_len = tdata[5][7:0];
        for (i = 0; i < 64; i = i + 1)
            frame[i] = tdata[6 + i];
        seed = 32'h4a8dbcbc;
        cycles = 0;
        mem_beats = 0;
        report = 1'b0;
        init_calib_complete = 1'b1;
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd_data_valid = 1'b0;
        app_rd_data = '0;
        wr_load = 1'b0;
        rd_load = 1'b0;
        wrfifo_wren = 1'b0;
        wrfifo_din = '0;
        rdfifo_rden = 1'b0;

        wait (rst_n === 1'b1);
        repeat (4) @(posedge ui_clk);
        pulse_load(1'b1);
        push_words(64);
        while (mem_beats < 8) @(posedge ui_clk);
        pulse_load(1'b0);
        rdfifo_rden <= 1'b1;
        while (rd_words < 64) @(posedge ui_clk);
        rdfifo_rden <= 1'b0;

        push_words(16);                         // write address moves past the wrap
        while (mem_beats < 10) @(posedge ui_clk);
        pulse_load(1'b1);                       // mid-run write restart
        push_words(16);
        while (mem_beats < 12) @(posedge ui_clk);
        rdfifo_rden <= 1'b1;
        while (rd_words < 128) @(posedge ui_clk);
        rdfifo_rden <= 1'b0;
        repeat (4) @(posedge ui_clk);
        report <= 1'b1;
        while (!chk_done) @(posedge ui_clk);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/ddr_fb_testdata.hex */
// wr_min wr_max rd_min rd_max wr_burst_len rd_burst_len
// then 64 frame words, one beat of eight words per line
00000100 00000140 00000100 00000140 00000002 00000002
a0000000 a0010101 a0020202 a0030303 a0040404 a0050505 a0060606 a0070707
b1000008 b1010109 b102020a b103030b b104040c b105050d b106060e b107070f
c2000010 c2010111 c2020212 c2030313 c2040414 c2050515 c2060616 c2070717
d3000018 d3010119 d302021a d303031b d304041c d305051d d306061e d307071f
e4000020 e4010121 e4020222 e4030323 e4040424 e4050525 e4060626 e4070727
f5000028 f5010129 f502022a f503032b f504042c f505052d f506062e f507072f
06000030 06010131 06020232 06030333 06040434 06050535 06060636 06070737
17000038 17010139 1702023a 1703033b 1704043c 1705053d 1706063e 1707073f

/* project.f */
src/ddr_fb_pkg.sv
src/ddr_fb_fsm.sv
src/burst_addr_counter.sv
src/wr_pack_fifo.sv
src/rd_unpack_fifo.sv
src/ddr_fb_top.sv
bench/tb_clk_gen.sv
bench/ddr_fb_sva.sv
bench/tb_checker.sv
bench/tb_ddr_fb.sv

/* Makefile */
SRCS := $(wildcard src/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_ddr_fb: $(SRCS) project.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_fb -f project.f

run: obj_dir/Vtb_ddr_fb bench/ddr_fb_testdata.hex
	./obj_dir/Vtb_ddr_fb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
